/* hdl/rv_decode_pkg.sv */
/*
 * RV32I decode definitions
 * ISA widths, instruction field positions, opcode and funct3 encodings
 * and the core's private NOP word used by the decode stage.
 */
package rv_decode_pkg;

    // widths fixed by the ISA
    localparam int INST_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int REG_ADDR_W = 5;

    // instruction field layout
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int OPCODE_LSB = 0;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;

    // private nop, opcode 0000001, all other fields zero
    localparam logic [INST_W-1:0] INST_NOP = 32'h0000_0001;

    typedef enum logic [OPCODE_W-1:0] {
        OP_IMM    = 7'b0010011,  // addi, slti, xori, shifts
        OP_REG    = 7'b0110011,  // add/sub, sll, slt, and ...
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_FENCE  = 7'b0001111,
        OP_NOP    = 7'b0000001   // core specific
    } opcode_e;

    typedef enum logic [FUNCT3_W-1:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        SB = 3'b000,
        SH = 3'b001,
        SW = 3'b010
    } store_f3_e;

    typedef enum logic [FUNCT3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

endpackage

/* hdl/id_decoder.sv */
/*
 * ID decoder
 * Combinational classifier of one RV32I instruction. Produces register
 * file read/write controls, data memory enables and a valid flag.
 * Every output is decoded fresh; an address is zero when its enable is low.
 */
`timescale 1ns/1ps

module id_decoder (
    input  logic [rv_decode_pkg::INST_W-1:0]     inst_i,

    output logic                                 valid_o,
    output logic                                 rs1_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic                                 rs2_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                                 rd_we_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_o,
    output logic                                 mem_re_o,
    output logic                                 mem_we_o
);
    import rv_decode_pkg::*;

    opcode_e               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;

    // field split
    assign opcode = opcode_e'(inst_i[OPCODE_LSB +: OPCODE_W]);
    assign funct3 = inst_i[FUNCT3_LSB +: FUNCT3_W];
    assign rd     = inst_i[RD_LSB +: REG_ADDR_W];
    assign rs1    = inst_i[RS1_LSB +: REG_ADDR_W];
    assign rs2    = inst_i[RS2_LSB +: REG_ADDR_W];

    always_comb begin
        valid_o  = 1'b0;
        rs1_re_o = 1'b0;
        rs2_re_o = 1'b0;
        rd_we_o  = 1'b0;
        mem_re_o = 1'b0;
        mem_we_o = 1'b0;

        case (opcode)
            OP_IMM: begin
                valid_o  = 1'b1;   // any funct3
                rs1_re_o = 1'b1;
                rd_we_o  = 1'b1;
            end

            OP_REG: begin
                valid_o  = 1'b1;   // funct7 checked in execute
                rs1_re_o = 1'b1;
                rs2_re_o = 1'b1;
                rd_we_o  = 1'b1;
            end

            OP_LOAD: begin
                case (load_f3_e'(funct3))
                    LB, LH, LW, LBU, LHU: begin
                        valid_o  = 1'b1;
                        rs1_re_o = 1'b1;
                        rd_we_o  = 1'b1;
                        mem_re_o = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end

            OP_STORE: begin
                case (store_f3_e'(funct3))
                    SB, SH: begin
                        valid_o  = 1'b1;
                        rs1_re_o = 1'b1;
                        rs2_re_o = 1'b1;
                        mem_we_o = 1'b1;
                        mem_re_o = 1'b1;   // sub-word store, read-modify-write
                    end
                    SW: begin
                        valid_o  = 1'b1;
                        rs1_re_o = 1'b1;
                        rs2_re_o = 1'b1;
                        mem_we_o = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end

            OP_BRANCH: begin
                case (branch_f3_e'(funct3))
                    BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                        valid_o  = 1'b1;
                        rs1_re_o = 1'b1;
                        rs2_re_o = 1'b1;
                    end
                    default: begin
                        valid_o = 1'b0;
                    end
                endcase
            end

            OP_JAL, OP_LUI, OP_AUIPC: begin
                valid_o = 1'b1;
                rd_we_o = 1'b1;
            end

            OP_JALR: begin
                valid_o  = 1'b1;
                rs1_re_o = 1'b1;
                rd_we_o  = 1'b1;
            end

            OP_FENCE, OP_NOP: begin
                valid_o = 1'b1;    // no side effects
            end

            default: begin
                valid_o = 1'b0;
            end
        endcase
    end

    // addresses only meaningful with their enable
    assign rs1_addr_o = rs1_re_o ? rs1 : '0;
    assign rs2_addr_o = rs2_re_o ? rs2 : '0;
    assign rd_addr_o  = rd_we_o  ? rd  : '0;

endmodule

/* hdl/id_pipe_reg.sv */
/*
 * ID pipeline register
 * Replaces the wrong-path instruction with the NOP on a taken jump and
 * registers the decoded controls for the execute stage.
 */
`timescale 1ns/1ps

module id_pipe_reg (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 jump_flag_i,
    input  logic [rv_decode_pkg::INST_W-1:0]     inst_i,
    input  logic [rv_decode_pkg::ADDR_W-1:0]     inst_addr_i,

    input  logic                                 valid_i,
    input  logic                                 rs1_re_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic                                 rs2_re_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                                 rd_we_i,
    input  logic [rv_decode_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic                                 mem_re_i,
    input  logic                                 mem_we_i,

    output logic [rv_decode_pkg::INST_W-1:0]     inst_o,
    output logic [rv_decode_pkg::ADDR_W-1:0]     inst_addr_o,
    output logic                                 inst_valid_o,
    output logic                                 reg1_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg1_raddr_o,
    output logic                                 reg2_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg2_raddr_o,
    output logic                                 reg_we_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic                                 sram_re_o,
    output logic                                 sram_we_o
);
    import rv_decode_pkg::*;

    logic                  flush;
    logic [INST_W-1:0]     inst_d;
    logic                  valid_d;
    logic                  rs1_re_d;
    logic [REG_ADDR_W-1:0] rs1_addr_d;
    logic                  rs2_re_d;
    logic [REG_ADDR_W-1:0] rs2_addr_d;
    logic                  rd_we_d;
    logic [REG_ADDR_W-1:0] rd_addr_d;
    logic                  mem_re_d;
    logic                  mem_we_d;

    // a nop already in the slot needs no squash
    assign flush = jump_flag_i && (inst_i != INST_NOP);

    always_comb begin
        if (flush) begin
            inst_d     = INST_NOP;
            valid_d    = 1'b1;
            rs1_re_d   = 1'b0;
            rs1_addr_d = '0;
            rs2_re_d   = 1'b0;
            rs2_addr_d = '0;
            rd_we_d    = 1'b0;
            rd_addr_d  = '0;
            mem_re_d   = 1'b0;
            mem_we_d   = 1'b0;
        end else begin
            inst_d     = inst_i;
            valid_d    = valid_i;
            rs1_re_d   = rs1_re_i;
            rs1_addr_d = rs1_addr_i;
            rs2_re_d   = rs2_re_i;
            rs2_addr_d = rs2_addr_i;
            rd_we_d    = rd_we_i;
            rd_addr_d  = rd_addr_i;
            mem_re_d   = mem_re_i;
            mem_we_d   = mem_we_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_o       <= '0;
            inst_addr_o  <= '0;
            inst_valid_o <= 1'b0;
            reg1_re_o    <= 1'b0;
            reg1_raddr_o <= '0;
            reg2_re_o    <= 1'b0;
            reg2_raddr_o <= '0;
            reg_we_o     <= 1'b0;
            reg_waddr_o  <= '0;
            sram_re_o    <= 1'b0;
            sram_we_o    <= 1'b0;
        end else begin
            inst_o       <= inst_d;
            inst_addr_o  <= inst_addr_i;   // kept on flush too
            inst_valid_o <= valid_d;
            reg1_re_o    <= rs1_re_d;
            reg1_raddr_o <= rs1_addr_d;
            reg2_re_o    <= rs2_re_d;
            reg2_raddr_o <= rs2_addr_d;
            reg_we_o     <= rd_we_d;
            reg_waddr_o  <= rd_addr_d;
            sram_re_o    <= mem_re_d;
            sram_we_o    <= mem_we_d;
        end
    end

endmodule

/* hdl/id_stage.sv */
/*
 * Instruction decode stage
 * One RV32I instruction per cycle in, registered decode controls out
 * one cycle later. A taken jump from execute squashes the incoming slot.
 */
`timescale 1ns/1ps

module id_stage (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic [rv_decode_pkg::INST_W-1:0]     inst_i,
    input  logic [rv_decode_pkg::ADDR_W-1:0]     inst_addr_i,
    input  logic                                 jump_flag_i,

    output logic [rv_decode_pkg::INST_W-1:0]     inst_o,
    output logic [rv_decode_pkg::ADDR_W-1:0]     inst_addr_o,
    output logic                                 inst_valid_o,
    output logic                                 reg1_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg1_raddr_o,
    output logic                                 reg2_re_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg2_raddr_o,
    output logic                                 reg_we_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0] reg_waddr_o,
    output logic                                 sram_re_o,
    output logic                                 sram_we_o
);
    import rv_decode_pkg::*;

    // decoder to pipeline register
    logic                  dec_valid;
    logic                  dec_rs1_re;
    logic [REG_ADDR_W-1:0] dec_rs1_addr;
    logic                  dec_rs2_re;
    logic [REG_ADDR_W-1:0] dec_rs2_addr;
    logic                  dec_rd_we;
    logic [REG_ADDR_W-1:0] dec_rd_addr;
    logic                  dec_mem_re;
    logic                  dec_mem_we;

    id_decoder u_decoder (
        .inst_i     (inst_i),
        .valid_o    (dec_valid),
        .rs1_re_o   (dec_rs1_re),
        .rs1_addr_o (dec_rs1_addr),
        .rs2_re_o   (dec_rs2_re),
        .rs2_addr_o (dec_rs2_addr),
        .rd_we_o    (dec_rd_we),
        .rd_addr_o  (dec_rd_addr),
        .mem_re_o   (dec_mem_re),
        .mem_we_o   (dec_mem_we)
    );

    id_pipe_reg u_pipe_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .jump_flag_i  (jump_flag_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .valid_i      (dec_valid),
        .rs1_re_i     (dec_rs1_re),
        .rs1_addr_i   (dec_rs1_addr),
        .rs2_re_i     (dec_rs2_re),
        .rs2_addr_i   (dec_rs2_addr),
        .rd_we_i      (dec_rd_we),
        .rd_addr_i    (dec_rd_addr),
        .mem_re_i     (dec_mem_re),
        .mem_we_i     (dec_mem_we),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o),
        .reg1_re_o    (reg1_re_o),
        .reg1_raddr_o (reg1_raddr_o),
        .reg2_re_o    (reg2_re_o),
        .reg2_raddr_o (reg2_raddr_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .sram_re_o    (sram_re_o),
        .sram_we_o    (sram_we_o)
    );

endmodule

/* include/id_expect.svh */
/*
 * Decode stage reference model
 * Expected registered controls for one instruction, from the RV32I
 * decode table of the stage and the squash rule for a taken jump.
 */
`ifndef ID_EXPECT_SVH
`define ID_EXPECT_SVH

// valid, rs1 re/addr, rs2 re/addr, rd we/addr, mem re, mem we
localparam int CTRL_W = 21;

function automatic logic [CTRL_W-1:0] expect_ctrl(
    input logic [INST_W-1:0] inst,
    input logic              jump
);
    logic [6:0] op;
    logic [2:0] f3;
    logic [5:0] flags;   // v r1 r2 w mr mw
    logic [4:0] a1;
    logic [4:0] a2;
    logic [4:0] ad;

    op    = inst[6:0];
    f3    = inst[14:12];
    flags = 6'b000000;
    if (jump && (inst != INST_NOP)) begin
        return {1'b1, {(CTRL_W-1){1'b0}}};   // squashed slot decodes as nop
    end
    case (op)
        OP_IMM:    flags = 6'b110100;
        OP_REG:    flags = 6'b111100;
        OP_LOAD: begin
            if (f3 inside {LB, LH, LW, LBU, LHU}) begin
                flags = 6'b110110;
            end
        end
        OP_STORE: begin
            if (f3 inside {SB, SH}) begin
                flags = 6'b111011;   // sub-word store also reads
            end else if (f3 == SW) begin
                flags = 6'b111001;
            end
        end
        OP_BRANCH: begin
            if (f3 inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}) begin
                flags = 6'b111000;
            end
        end
        OP_JAL, OP_LUI, OP_AUIPC: flags = 6'b100100;
        OP_JALR:   flags = 6'b110100;
        OP_FENCE, OP_NOP: flags = 6'b100000;
        default:   flags = 6'b000000;
    endcase
    a1 = flags[4] ? inst[19:15] : 5'd0;
    a2 = flags[3] ? inst[24:20] : 5'd0;
    ad = flags[2] ? inst[11:7]  : 5'd0;
    return {flags[5], flags[4], a1, flags[3], a2, flags[2], ad, flags[1], flags[0]};
endfunction

function automatic logic [INST_W-1:0] expect_inst(
    input logic [INST_W-1:0] inst,
    input logic              jump
);
    return (jump && (inst != INST_NOP)) ? INST_NOP : inst;
endfunction

`endif

/* tests/tb_id_stage.sv */
/*
 * Testbench for the instruction decode stage
 * Random instruction stream with jump squashes, checked one cycle
 * later by concurrent assertions against a reference model.
 */
`timescale 1ns/1ps

module tb_id_stage;
    import rv_decode_pkg::*;

    `include "id_expect.svh"

    localparam int CLK_HALF_NS = 20;
    localparam int RESET_CYC   = 8;
    localparam int NUM_INST    = 3000;
    localparam int TIMEOUT_NS  = (RESET_CYC + NUM_INST + 100) * 2 * CLK_HALF_NS;

    logic                  clk = 1'b0;
    logic                  rst_n_i;
    logic [INST_W-1:0]     inst_i;
    logic [ADDR_W-1:0]     inst_addr_i;
    logic                  jump_flag_i;
    logic [INST_W-1:0]     inst_o;
    logic [ADDR_W-1:0]     inst_addr_o;
    logic                  inst_valid_o;
    logic                  reg1_re_o;
    logic [REG_ADDR_W-1:0] reg1_raddr_o;
    logic                  reg2_re_o;
    logic [REG_ADDR_W-1:0] reg2_raddr_o;
    logic                  reg_we_o;
    logic [REG_ADDR_W-1:0] reg_waddr_o;
    logic                  sram_re_o;
    logic                  sram_we_o;

    logic [CTRL_W-1:0]     out_ctrl;
    logic [CTRL_W-1:0]     exp_ctrl;
    logic [INST_W-1:0]     exp_inst;
    logic [ADDR_W-1:0]     exp_addr;
    int                    err_reset = 0;
    int                    err_decode = 0;
    int                    err_pass = 0;

    id_stage u_id_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .jump_flag_i  (jump_flag_i),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o),
        .reg1_re_o    (reg1_re_o),
        .reg1_raddr_o (reg1_raddr_o),
        .reg2_re_o    (reg2_re_o),
        .reg2_raddr_o (reg2_raddr_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .sram_re_o    (sram_re_o),
        .sram_we_o    (sram_we_o)
    );

    always #(CLK_HALF_NS) clk = ~clk;

    assign out_ctrl = {inst_valid_o, reg1_re_o, reg1_raddr_o, reg2_re_o, reg2_raddr_o,
                       reg_we_o, reg_waddr_o, sram_re_o, sram_we_o};

    a_reset_quiet: assert property (@(posedge clk)
        rst_n_i || (out_ctrl == '0 && inst_o == '0 && inst_addr_o == '0))
        else begin
            err_reset = err_reset + 1;
            $display("Error %0t: outputs not cleared in reset", $time);
        end

    a_valid: assert property (@(posedge clk) inst_valid_o == exp_ctrl[CTRL_W-1])
        else begin
            err_decode = err_decode + 1;
            $display("Error %0t: valid %b expected %b for inst %h", $time,
                     inst_valid_o, exp_ctrl[CTRL_W-1], exp_inst);
        end

    a_regs: assert property (@(posedge clk) out_ctrl[CTRL_W-2:2] == exp_ctrl[CTRL_W-2:2])
        else begin
            err_decode = err_decode + 1;
            $display("Error %0t: register controls %h expected %h for inst %h", $time,
                     out_ctrl[CTRL_W-2:2], exp_ctrl[CTRL_W-2:2], exp_inst);
        end

    a_mem: assert property (@(posedge clk) {sram_re_o, sram_we_o} == exp_ctrl[1:0])
        else begin
            err_decode = err_decode + 1;
            $display("Error %0t: sram re/we %b%b expected %b for inst %h", $time,
                     sram_re_o, sram_we_o, exp_ctrl[1:0], exp_inst);
        end

    a_inst: assert property (@(posedge clk) inst_o == exp_inst)
        else begin
            err_pass = err_pass + 1;
            $display("Error %0t: inst_o %h expected %h", $time, inst_o, exp_inst);
        end

    a_addr: assert property (@(posedge clk) inst_addr_o == exp_addr)
        else begin
            err_pass = err_pass + 1;
            $display("Error %0t: inst_addr_o %h expected %h", $time, inst_addr_o, exp_addr);
        end

    // mix of legal classes, bad funct3, random words and nops
    function automatic logic [INST_W-1:0] make_inst();
        logic [31:0] word;
        logic [31:0] pick;
        logic [2:0]  f3;
        opcode_e     oe;

        word = $urandom;
        pick = $urandom;
        f3   = word[14:12];
        oe   = oe.first();
        if (pick[3:0] < 4'd10) begin
            repeat (int'(pick[7:4]) % 11) oe = oe.next();
            if (oe == OP_LOAD && !(f3 inside {LB, LH, LW, LBU, LHU})) f3 = LBU;
            if (oe == OP_STORE && !(f3 inside {SB, SH, SW})) f3 = SH;
            if (oe == OP_BRANCH && !(f3 inside {BEQ, BNE, BLT, BGE, BLTU, BGEU})) f3 = BGEU;
            word[6:0]   = oe;
            word[14:12] = f3;
        end else if (pick[3:0] < 4'd12) begin
            // any funct3 on the classes that restrict it
            word[6:0] = (pick[5:4] == 2'd0) ? OP_LOAD :
                        (pick[5:4] == 2'd1) ? OP_STORE : OP_BRANCH;
        end else if (pick[3:0] >= 4'd14) begin
            word = INST_NOP;
        end
        return word;
    endfunction

    task automatic drive_next();
        logic [31:0] rnd;

        inst_i      = make_inst();
        rnd         = $urandom;
        inst_addr_i = {rnd[31:2], 2'b00};
        rnd         = $urandom;
        jump_flag_i = (rnd[2:0] == 3'd0);   // about one in eight
    endtask

    task automatic capture_expect();
        exp_ctrl = expect_ctrl(inst_i, jump_flag_i);
        exp_inst = expect_inst(inst_i, jump_flag_i);
        exp_addr = inst_addr_i;
    endtask

    initial begin
        int total;

        void'($urandom(1));
        rst_n_i     = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        jump_flag_i = 1'b0;
        exp_ctrl    = '0;
        exp_inst    = '0;
        exp_addr    = '0;
        // instructions keep arriving while reset holds the outputs
        repeat (RESET_CYC) begin
            @(negedge clk);
            drive_next();
        end
        rst_n_i = 1'b1;   // first edge after release still shows reset values
        for (int n = 1; n < NUM_INST; n++) begin
            @(negedge clk);
            capture_expect();
            drive_next();
        end
        @(negedge clk);
        capture_expect();
        repeat (2) @(negedge clk);
        total = err_reset + err_decode + err_pass;
        $display("reset errors %0d, decode errors %0d, pass-through errors %0d",
                 err_reset, err_decode, err_pass);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the instruction stream finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
hdl/rv_decode_pkg.sv
hdl/id_decoder.sv
hdl/id_pipe_reg.sv
hdl/id_stage.sv
tests/tb_id_stage.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f all.f --top-module tb_id_stage -o sim_tb_id_stage

sim_out=$(./obj_dir/sim_tb_id_stage)
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "simulation did not report a pass"
exit 1
